// ==== Makefile ====
# Verilator build and run for the decode/execute slice

VERILATOR  ?= verilator
TOP        ?= decodeExecTb
RTL_TOP    ?= decodeExecTop
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# Exit status of the simulation is the test result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== decodeExecTb.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "pipe_defines.svh"

module decodeExecTb;

  localparam int numInstr    = 400;
  localparam int halfPeriod  = 10;
  localparam int resetCycles = 8;
  localparam int timeoutNs   = numInstr * 12 * 2 * halfPeriod;

  // R-type function codes
  localparam logic [5:0] fnSll = 6'h00;
  localparam logic [5:0] fnSrl = 6'h02;
  localparam logic [5:0] fnSra = 6'h03;
  localparam logic [5:0] fnAdd = 6'h20;
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr  = 6'h25;
  localparam logic [5:0] fnXor = 6'h26;
  localparam logic [5:0] fnNor = 6'h27;
  localparam logic [5:0] fnSlt = 6'h2a;

  logic                Clk;
  logic                rst;
  pipePkg::fetchBundle inInstr;
  logic                inValid;
  logic                inReady;
  pipePkg::exResult    res;
  logic                resValid;
  logic                resReady;

  logic [`DATA_W-1:0]  modelRegs [`NUM_REGS];
  pipePkg::exResult    expQ [$];
  logic                inFire = 1'b0;
  int                  gotCount = 0;

  decodeExecTop dut0 (
    .Clk      (Clk),
    .rst      (rst),
    .inInstr  (inInstr),
    .inValid  (inValid),
    .inReady  (inReady),
    .res      (res),
    .resValid (resValid),
    .resReady (resReady)
  );

  always #halfPeriod Clk = ~Clk;

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // Mostly low registers so neighbours depend on each other
  function automatic logic [`REG_AW-1:0] pickReg();
    if ($urandom_range(0, 9) < 8) return `REG_AW'($urandom_range(0, 7));
    return `REG_AW'($urandom_range(0, 31));
  endfunction

  function automatic logic [5:0] functCode(int k);
    case (k)
      0: return fnAdd;
      1: return fnSub;
      2: return fnAnd;
      3: return fnOr;
      4: return fnXor;
      5: return fnNor;
      6: return fnSlt;
      7: return fnSll;
      8: return fnSrl;
      default: return fnSra;
    endcase
  endfunction

  function automatic pipePkg::instrWord randomInstr();
    pipePkg::instrWord w;
    logic [31:0]       bits;
    int                kind;
    bits = $urandom();
    kind = int'($urandom_range(0, 21));
    w.rFields.opcode = pipePkg::opRType;
    w.rFields.rs     = pickReg();
    w.rFields.rt     = pickReg();
    w.rFields.rd     = pickReg();
    w.rFields.shamt  = bits[4:0];
    w.rFields.funct  = functCode(kind);
    case (kind)
      10, 21: w.iFields.opcode = pipePkg::opAddi;
      11: w.iFields.opcode = pipePkg::opAndi;
      12: w.iFields.opcode = pipePkg::opOri;
      13: w.iFields.opcode = pipePkg::opXori;
      14: w.iFields.opcode = pipePkg::opSlti;
      15: w.iFields.opcode = pipePkg::opLui;
      16: w.iFields.opcode = pipePkg::opBeq;
      17: w.iFields.opcode = pipePkg::opBne;
      18: w.iFields.opcode = pipePkg::opJal;
      // Load opcodes are outside this slice
      19: w.iFields.opcode = {3'b100, bits[8:6]};
      20: w.rFields.funct = {2'b01, bits[9:6]};
      default: ;
    endcase
    if (kind >= 10 && kind != 20) w.iFields.imm16 = bits[31:16];
    // Equal operands now and then so branches get taken
    if ((kind == 16 || kind == 17) && bits[5]) w.iFields.rt = w.iFields.rs;
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic pipePkg::exResult refExec(pipePkg::fetchBundle fb,
                                               logic [`DATA_W-1:0] regs [`NUM_REGS]);
    pipePkg::exResult   r;
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
    logic [`DATA_W-1:0] sImm;
    logic [`DATA_W-1:0] zImm;
    logic [5:0]         op;
    logic [4:0]         sh;
    logic [`REG_AW-1:0] dest;
    logic               writes;
    op     = fb.instr.iFields.opcode;
    sh     = fb.instr.rFields.shamt;
    a      = regs[fb.instr.rFields.rs];
    b      = regs[fb.instr.rFields.rt];
    sImm   = {{16{fb.instr.iFields.imm16[15]}}, fb.instr.iFields.imm16};
    zImm   = {16'h0000, fb.instr.iFields.imm16};
    r      = '0;
    dest   = fb.instr.iFields.rt;
    writes = 1'b1;
    case (op)
      pipePkg::opRType: begin
        dest = fb.instr.rFields.rd;
        case (fb.instr.rFields.funct)
          fnAdd: r.value = a + b;
          fnSub: r.value = a - b;
          fnAnd: r.value = a & b;
          fnOr:  r.value = a | b;
          fnXor: r.value = a ^ b;
          fnNor: r.value = ~(a | b);
          fnSlt: r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          fnSll: r.value = b << sh;
          fnSrl: r.value = b >> sh;
          fnSra: r.value = $signed(b) >>> sh;
          default: writes = 1'b0;
        endcase
      end
      pipePkg::opAddi: r.value = a + sImm;
      pipePkg::opSlti: r.value = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
      pipePkg::opAndi: r.value = a & zImm;
      pipePkg::opOri:  r.value = a | zImm;
      pipePkg::opXori: r.value = a ^ zImm;
      pipePkg::opLui:  r.value = {fb.instr.iFields.imm16, 16'h0000};
      pipePkg::opBeq, pipePkg::opBne: begin
        writes     = 1'b0;
        r.isBranch = 1'b1;
        r.taken    = (a == b) ^ (op == pipePkg::opBne);
        r.target   = fb.pcPlus4 + (sImm << 2);
      end
      pipePkg::opJal: begin
        dest       = `REG_AW'(`LINK_REG);
        r.value    = fb.pcPlus4;
        r.isBranch = 1'b1;
        r.taken    = 1'b1;
        r.target   = {fb.pcPlus4[31:28], fb.instr.iFields.rs, fb.instr.iFields.rt,
                      fb.instr.iFields.imm16, 2'b00};
      end
      default: writes = 1'b0;
    endcase
    r.writeReg = dest;
    r.writeEn  = writes && (dest != '0);
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic stopOnFailure();
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  // Destination and value only matter when a write happens
  task automatic checkWrite(pipePkg::exResult got, pipePkg::exResult exp);
    if (got.writeEn !== exp.writeEn ||
        (exp.writeEn && (got.writeReg !== exp.writeReg || got.value !== exp.value))) begin
      $display("error: %0t ns write got en=%0b r%0d=%h, expected en=%0b r%0d=%h", $time,
               got.writeEn, got.writeReg, got.value, exp.writeEn, exp.writeReg, exp.value);
      stopOnFailure();
    end
  endtask

  task automatic checkBranch(pipePkg::exResult got, pipePkg::exResult exp);
    if (got.isBranch !== exp.isBranch || got.taken !== exp.taken ||
        (exp.isBranch && got.target !== exp.target)) begin
      $display("error: %0t ns branch got br=%0b tk=%0b tgt=%h, expected br=%0b tk=%0b tgt=%h",
               $time, got.isBranch, got.taken, got.target,
               exp.isBranch, exp.taken, exp.target);
      stopOnFailure();
    end
  endtask

  // Handshakes are sampled mid-cycle where everything is settled
  always @(negedge Clk) begin : trackInputs
    pipePkg::exResult expRes;
    if (inFire && !resValid) begin
      $display("error: %0t ns resValid low in the cycle after an accepted instruction",
               $time);
      stopOnFailure();
    end else if (!rst && inReady !== (!resValid || resReady)) begin
      // Ready only when the stage is empty or its result leaves this cycle
      $display("error: %0t ns inReady=%0b with resValid=%0b resReady=%0b", $time,
               inReady, resValid, resReady);
      stopOnFailure();
    end else begin
      inFire = !rst && inValid && inReady;
      if (inFire) begin
        expRes = refExec(inInstr, modelRegs);
        if (expRes.writeEn) modelRegs[expRes.writeReg] = expRes.value;
        expQ.push_back(expRes);
      end
    end
  end

  always @(negedge Clk) begin : compareResults
    pipePkg::exResult expRes;
    if (!rst && resValid && resReady) begin
      if (expQ.size() == 0) begin
        $display("error: %0t ns result arrived with no instruction outstanding", $time);
        stopOnFailure();
      end else begin
        expRes = expQ.pop_front();
        checkWrite(res, expRes);
        checkBranch(res, expRes);
        gotCount++;
      end
    end
  end

  initial begin : watchdog
    #(timeoutNs);
    $display("Timeout: results stopped arriving, %0d of %0d received", gotCount, numInstr);
    stopOnFailure();
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin : runTest
    int issued;
    void'($urandom(32'h4b9c));
    Clk      = 1'b0;
    rst      = 1'b1;
    inInstr  = '0;
    inValid  = 1'b0;
    resReady = 1'b0;
    issued   = 0;
    for (int i = 0; i < `NUM_REGS; i++) begin
      modelRegs[i] = '0;
    end
    repeat (resetCycles) @(posedge Clk);
    #2;
    rst = 1'b0;
    while (issued < numInstr || inValid) begin
      @(posedge Clk);
      #2;
      if (inFire) inValid = 1'b0;
      if (!inValid && issued < numInstr && $urandom_range(0, 3) != 0) begin
        inInstr.instr   = randomInstr();
        inInstr.pcPlus4 = {4'($urandom_range(0, 15)), 26'(issued), 2'b00};
        inValid         = 1'b1;
        issued++;
      end
      resReady = ($urandom_range(0, 3) != 0);
    end
    // Drain what is left in the stage
    resReady = 1'b1;
    while (gotCount < numInstr) @(posedge Clk);
    repeat (4) @(posedge Clk);
    if (expQ.size() != 0 || gotCount != numInstr || resValid) begin
      $display("error: %0t ns %0d results received, %0d still expected", $time,
               gotCount, expQ.size());
      stopOnFailure();
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== decodeExecTop.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "pipe_defines.svh"

module decodeExecTop (
  input  logic                Clk,
  input  logic                rst,
  input  pipePkg::fetchBundle inInstr,
  input  logic                inValid,
  output logic                inReady,
  output pipePkg::exResult    res,
  output logic                resValid,
  input  logic                resReady
);

  pipePkg::decodeCtrl decCtrl;
  pipePkg::idExBundle decBundle;
  pipePkg::idExBundle exBundle;
  logic [`REG_AW-1:0] rsAddr;
  logic [`REG_AW-1:0] rtAddr;
  logic [`DATA_W-1:0] readData1;
  logic [`DATA_W-1:0] readData2;
  logic               stageValid;
  logic               advance;
  logic               load;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  assign advance  = stageValid && resReady;
  assign inReady  = !stageValid || advance;
  assign load     = inValid && inReady;
  assign resValid = stageValid;

  instrDecode decode0 (
    .instr (inInstr.instr),
    .ctrl  (decCtrl),
    .rs    (rsAddr),
    .rt    (rtAddr)
  );

  // Write back only when the result is actually taken
  regFile regs0 (
    .Clk       (Clk),
    .rst       (rst),
    .readAddr1 (rsAddr),
    .readAddr2 (rtAddr),
    .readData1 (readData1),
    .readData2 (readData2),
    .writeEn   (res.writeEn && advance),
    .writeAddr (res.writeReg),
    .writeData (res.value)
  );

  assign decBundle = '{
    ctrl:      decCtrl,
    readData1: readData1,
    readData2: readData2,
    shamt:     inInstr.instr.rFields.shamt,
    pcPlus4:   inInstr.pcPlus4
  };

  idExStage stage0 (
    .Clk        (Clk),
    .rst        (rst),
    .load       (load),
    .drain      (advance),
    .inBundle   (decBundle),
    .stageValid (stageValid),
    .outBundle  (exBundle)
  );

  execUnit exec0 (
    .stage  (exBundle),
    .result (res)
  );

endmodule

`default_nettype wire

// ==== decodeExec_assert.sv ====
`default_nettype none
`timescale 1ns/10ps

module decodeExecAssert (
  input logic             Clk,
  input logic             rst,
  input logic             resValid,
  input logic             resReady,
  input pipePkg::exResult res
);

  ////////////////////////////////////////////////////////////
  // Output handshake
  ////////////////////////////////////////////////////////////

  // Stage comes out of reset empty
  resetEmpty: assert property (@(posedge Clk) rst |=> !resValid)
    else $error("resValid high right after a reset cycle");

  // A stalled result keeps its payload
  holdStable: assert property (@(posedge Clk) disable iff (rst)
    (resValid && !resReady) |=> (resValid && $stable(res)))
    else $error("result changed or dropped while stalled");

  // Register zero is never a write target
  noZeroWrite: assert property (@(posedge Clk) disable iff (rst)
    resValid |-> !(res.writeEn && (res.writeReg == '0)))
    else $error("result writes register zero");

endmodule

bind decodeExecTop decodeExecAssert assert0 (
  .Clk      (Clk),
  .rst      (rst),
  .resValid (resValid),
  .resReady (resReady),
  .res      (res)
);

`default_nettype wire

// ==== execUnit.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "pipe_defines.svh"

module execUnit (
  input  pipePkg::idExBundle stage,
  output pipePkg::exResult   result
);

  logic [`DATA_W-1:0] opA;
  logic [`DATA_W-1:0] opB;
  logic [4:0]         shAmt;
  logic [`DATA_W-1:0] aluOut;
  logic [`DATA_W-1:0] branchTarget;
  logic [`DATA_W-1:0] jumpTarget;
  logic               operandsEqual;

  assign opA = stage.readData1;
  assign opB = stage.ctrl.aluSrcImm ? stage.ctrl.immExt : stage.readData2;

  // Shift amount only for the shamt-form shifts
  assign shAmt = stage.ctrl.shiftByShamt ? stage.shamt : 5'd0;

  ////////////////////////////////////////////////////////////
  // ALU and shifter
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (stage.ctrl.aluOp)
      pipePkg::aluAdd: aluOut = opA + opB;
      pipePkg::aluSub: aluOut = opA - opB;
      pipePkg::aluAnd: aluOut = opA & opB;
      pipePkg::aluOr:  aluOut = opA | opB;
      pipePkg::aluXor: aluOut = opA ^ opB;
      pipePkg::aluNor: aluOut = ~(opA | opB);
      pipePkg::aluSlt: aluOut = {31'd0, $signed(opA) < $signed(opB)};
      pipePkg::aluSll: aluOut = stage.readData2 << shAmt;
      pipePkg::aluSrl: aluOut = stage.readData2 >> shAmt;
      pipePkg::aluSra: aluOut = $unsigned($signed(stage.readData2) >>> shAmt);
      // Immediate already placed in the upper half by decode
      pipePkg::aluLui: aluOut = opB;
      default:         aluOut = opA + opB;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Branch compare and jump targets
  ////////////////////////////////////////////////////////////

  assign operandsEqual = (stage.readData1 == stage.readData2);
  assign branchTarget  = stage.pcPlus4 + {stage.ctrl.immExt[`DATA_W-3:0], 2'b00};
  assign jumpTarget    = {stage.pcPlus4[31:28], stage.ctrl.immExt[25:0], 2'b00};

  always_comb begin
    result          = '0;
    result.writeEn  = stage.ctrl.regWrite;
    result.writeReg = stage.ctrl.writeReg;
    result.value    = aluOut;
    result.isBranch = stage.ctrl.isBranch || stage.ctrl.isJal;
    if (stage.ctrl.isJal) begin
      // Link value is the return address
      result.value  = stage.pcPlus4;
      result.taken  = 1'b1;
      result.target = jumpTarget;
    end else if (stage.ctrl.isBranch) begin
      result.taken  = operandsEqual ^ stage.ctrl.branchNe;
      result.target = branchTarget;
    end
  end

endmodule

`default_nettype wire

// ==== idExStage.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "pipe_defines.svh"

module idExStage (
  input  logic               Clk,
  input  logic               rst,
  input  logic               load,
  input  logic               drain,
  input  pipePkg::idExBundle inBundle,
  output logic               stageValid,
  output pipePkg::idExBundle outBundle
);

  pipePkg::decodeCtrl ctrlQ;
  logic [`DATA_W-1:0] readData1Q;
  logic [`DATA_W-1:0] readData2Q;
  logic [4:0]         shamtQ;
  logic [`DATA_W-1:0] pcPlus4Q;

  ////////////////////////////////////////////////////////////
  // Valid flag and control fields
  ////////////////////////////////////////////////////////////

  always_ff @(posedge Clk) begin
    if (rst) begin
      stageValid <= 1'b0;
      ctrlQ      <= '0;
    end else if (load) begin
      stageValid <= 1'b1;
      ctrlQ      <= inBundle.ctrl;
    end else if (drain) begin
      // Emptied with nothing new behind it
      stageValid <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Operand payload
  ////////////////////////////////////////////////////////////

  always_ff @(posedge Clk) begin
    if (load) begin
      readData1Q <= inBundle.readData1;
      readData2Q <= inBundle.readData2;
      shamtQ     <= inBundle.shamt;
      pcPlus4Q   <= inBundle.pcPlus4;
    end
  end

  assign outBundle = '{
    ctrl:      ctrlQ,
    readData1: readData1Q,
    readData2: readData2Q,
    shamt:     shamtQ,
    pcPlus4:   pcPlus4Q
  };

endmodule

`default_nettype wire

// ==== instrDecode.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "pipe_defines.svh"

module instrDecode (
  input  pipePkg::instrWord  instr,
  output pipePkg::decodeCtrl ctrl,
  output logic [`REG_AW-1:0] rs,
  output logic [`REG_AW-1:0] rt
);

  // R-type function codes
  localparam logic [5:0] fnSll = 6'h00;
  localparam logic [5:0] fnSrl = 6'h02;
  localparam logic [5:0] fnSra = 6'h03;
  localparam logic [5:0] fnAdd = 6'h20;
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr  = 6'h25;
  localparam logic [5:0] fnXor = 6'h26;
  localparam logic [5:0] fnNor = 6'h27;
  localparam logic [5:0] fnSlt = 6'h2a;

  logic [`DATA_W-1:0] immSign;
  logic [`DATA_W-1:0] immZero;
  logic [`DATA_W-1:0] immUpper;
  logic [`DATA_W-1:0] jalIndex;
  logic               validOp;

  assign rs = instr.iFields.rs;
  assign rt = instr.iFields.rt;

  assign immSign  = {{16{instr.iFields.imm16[15]}}, instr.iFields.imm16};
  assign immZero  = {16'd0, instr.iFields.imm16};
  assign immUpper = {instr.iFields.imm16, 16'd0};
  // 26-bit jump index, zero extended
  assign jalIndex = {6'd0, instr.iFields.rs, instr.iFields.rt, instr.iFields.imm16};

  always_comb begin
    ctrl          = '0;
    ctrl.aluOp    = pipePkg::aluAdd;
    ctrl.writeReg = instr.iFields.rt;
    ctrl.immExt   = immSign;
    validOp       = 1'b1;
    case (instr.iFields.opcode)
      pipePkg::opRType: begin
        ctrl.writeReg = instr.rFields.rd;
        case (instr.rFields.funct)
          fnAdd: ctrl.aluOp = pipePkg::aluAdd;
          fnSub: ctrl.aluOp = pipePkg::aluSub;
          fnAnd: ctrl.aluOp = pipePkg::aluAnd;
          fnOr:  ctrl.aluOp = pipePkg::aluOr;
          fnXor: ctrl.aluOp = pipePkg::aluXor;
          fnNor: ctrl.aluOp = pipePkg::aluNor;
          fnSlt: ctrl.aluOp = pipePkg::aluSlt;
          fnSll: begin
            ctrl.aluOp        = pipePkg::aluSll;
            ctrl.shiftByShamt = 1'b1;
          end
          fnSrl: begin
            ctrl.aluOp        = pipePkg::aluSrl;
            ctrl.shiftByShamt = 1'b1;
          end
          fnSra: begin
            ctrl.aluOp        = pipePkg::aluSra;
            ctrl.shiftByShamt = 1'b1;
          end
          default: validOp = 1'b0;
        endcase
      end
      pipePkg::opAddi: ctrl.aluSrcImm = 1'b1;
      pipePkg::opSlti: begin
        ctrl.aluOp     = pipePkg::aluSlt;
        ctrl.aluSrcImm = 1'b1;
      end
      pipePkg::opAndi: begin
        ctrl.aluOp     = pipePkg::aluAnd;
        ctrl.aluSrcImm = 1'b1;
        ctrl.immExt    = immZero;
      end
      pipePkg::opOri: begin
        ctrl.aluOp     = pipePkg::aluOr;
        ctrl.aluSrcImm = 1'b1;
        ctrl.immExt    = immZero;
      end
      pipePkg::opXori: begin
        ctrl.aluOp     = pipePkg::aluXor;
        ctrl.aluSrcImm = 1'b1;
        ctrl.immExt    = immZero;
      end
      pipePkg::opLui: begin
        ctrl.aluOp     = pipePkg::aluLui;
        ctrl.aluSrcImm = 1'b1;
        ctrl.immExt    = immUpper;
      end
      pipePkg::opBeq: ctrl.isBranch = 1'b1;
      pipePkg::opBne: begin
        ctrl.isBranch = 1'b1;
        ctrl.branchNe = 1'b1;
      end
      pipePkg::opJal: begin
        ctrl.isJal    = 1'b1;
        ctrl.writeReg = `REG_AW'(`LINK_REG);
        ctrl.immExt   = jalIndex;
      end
      default: validOp = 1'b0;
    endcase
    // Unknown encodings, branches and r0 targets retire without a write
    ctrl.regWrite = validOp && !ctrl.isBranch && (ctrl.writeReg != '0);
  end

endmodule

`default_nettype wire

// ==== pipePkg.sv ====
`default_nettype none
`include "pipe_defines.svh"

package pipePkg;

  ////////////////////////////////////////////////////////////
  // Instruction word, decoded as R or I format
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [5:0]         opcode;
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rt;
    logic [`REG_AW-1:0] rd;
    logic [4:0]         shamt;
    logic [5:0]         funct;
  } rFieldsT;

  typedef struct packed {
    logic [5:0]         opcode;
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rt;
    logic [15:0]        imm16;
  } iFieldsT;

  // jal index spans rs, rt and imm16 of the I view
  typedef union packed {
    rFieldsT rFields;
    iFieldsT iFields;
  } instrWord;

  typedef enum logic [5:0] {
    opRType = 6'h00,
    opJal   = 6'h03,
    opBeq   = 6'h04,
    opBne   = 6'h05,
    opAddi  = 6'h08,
    opSlti  = 6'h0a,
    opAndi  = 6'h0c,
    opOri   = 6'h0d,
    opXori  = 6'h0e,
    opLui   = 6'h0f
  } opcodeE;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
    aluSlt, aluSll, aluSrl, aluSra, aluLui
  } aluOpE;

  ////////////////////////////////////////////////////////////
  // Stage bundles
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    instrWord           instr;
    logic [`DATA_W-1:0] pcPlus4;
  } fetchBundle;

  typedef struct packed {
    aluOpE              aluOp;
    logic               aluSrcImm;
    logic               shiftByShamt;
    logic               regWrite;
    logic [`REG_AW-1:0] writeReg;
    logic               isBranch;
    logic               branchNe;
    logic               isJal;
    logic [`DATA_W-1:0] immExt;
  } decodeCtrl;

  typedef struct packed {
    decodeCtrl          ctrl;
    logic [`DATA_W-1:0] readData1;
    logic [`DATA_W-1:0] readData2;
    logic [4:0]         shamt;
    logic [`DATA_W-1:0] pcPlus4;
  } idExBundle;

  typedef struct packed {
    logic               writeEn;
    logic [`REG_AW-1:0] writeReg;
    logic [`DATA_W-1:0] value;
    logic               isBranch;
    logic               taken;
    logic [`DATA_W-1:0] target;
  } exResult;

endpackage

`default_nettype wire

// ==== pipe_defines.svh ====
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

////////////////////////////////////////////////////////////
// Datapath and register file sizing
////////////////////////////////////////////////////////////

// Integer datapath width
`define DATA_W 32

// Register address and register count
`define REG_AW 5
`define NUM_REGS 32

// Return address register written by jal
`define LINK_REG 31

`endif

// ==== regFile.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "pipe_defines.svh"

module regFile (
  input  logic               Clk,
  input  logic               rst,
  input  logic [`REG_AW-1:0] readAddr1,
  input  logic [`REG_AW-1:0] readAddr2,
  output logic [`DATA_W-1:0] readData1,
  output logic [`DATA_W-1:0] readData2,
  input  logic               writeEn,
  input  logic [`REG_AW-1:0] writeAddr,
  input  logic [`DATA_W-1:0] writeData
);

  // Register zero has no storage
  logic [`DATA_W-1:0] regs [1:`NUM_REGS-1];
  logic               writeActive;

  assign writeActive = writeEn && (writeAddr != '0);

  always_ff @(posedge Clk) begin
    if (rst) begin
      for (int i = 1; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (writeActive) begin
      regs[writeAddr] <= writeData;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read ports with write-through bypass
  ////////////////////////////////////////////////////////////

  assign readData1 = (readAddr1 == '0) ? '0 :
                     (writeActive && (writeAddr == readAddr1)) ? writeData :
                     regs[readAddr1];

  assign readData2 = (readAddr2 == '0) ? '0 :
                     (writeActive && (writeAddr == readAddr2)) ? writeData :
                     regs[readAddr2];

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
pipePkg.sv
instrDecode.sv
regFile.sv
idExStage.sv
execUnit.sv
decodeExecTop.sv
decodeExec_assert.sv
decodeExecTb.sv
